// File: sources.f
hdl/game_cfg_pkg.sv
hdl/ctrl_pkg.sv
hdl/control_merge.sv
hdl/frame_spinner.sv
hdl/mouse_tracker.sv
hdl/input_port_mux.sv
hdl/input_subsystem.sv
bench/input_subsystem_tb.sv

// File: Bender.yml
package:
  name: input_subsystem

sources:
  - hdl/game_cfg_pkg.sv
  - hdl/ctrl_pkg.sv
  - hdl/control_merge.sv
  - hdl/frame_spinner.sv
  - hdl/mouse_tracker.sv
  - hdl/input_port_mux.sv
  - hdl/input_subsystem.sv
  - target: test
    files:
      - bench/input_subsystem_tb.sv

// File: bench/input_subsystem_tb.sv
/* testbench for the player-control front end, with stimulus table,
   reference model, LFSR and compare tasks */

`timescale 1ns/1ps

module input_subsystem_tb;
	import game_cfg_pkg::*;
	import ctrl_pkg::*;

	typedef struct packed {
		game_id_t     game;
		joy_word_t    joy0;
		joy_word_t    joy1;
		logic         rotate;
		logic         joyswap;
		logic         service;
		logic         vs_pulse;
		logic         strobe;
		mouse_delta_t dx;
		mouse_delta_t dy;
		logic [7:0]   flags;
		logic [7:0]   exp_in0;
		logic [7:0]   exp_in1;
		logic [7:0]   exp_in2;
		logic [7:0]   exp_in3;
		logic [7:0]   exp_in4;
		spin_angle_t  exp_ang1;
		spin_angle_t  exp_ang2;
		kroozr_pos_t  exp_kx;
		kroozr_pos_t  exp_ky;
	} step_t;

	logic         clk_sys = 1'b0;
	logic         rst_n;
	game_id_t     game_sel;
	joy_word_t    joystick_0;
	joy_word_t    joystick_1;
	logic         rotate;
	logic         joyswap;
	logic         service;
	logic         vs;
	mouse_delta_t mouse_x;
	mouse_delta_t mouse_y;
	logic         mouse_strobe;
	logic [7:0]   mouse_flags;
	logic [7:0]   input_0;
	logic [7:0]   input_1;
	logic [7:0]   input_2;
	logic [7:0]   input_3;
	logic [7:0]   input_4;

	step_t        steps[$];
	int           num_rows = 0;
	int           cycle_count = 0;
	logic [31:0]  lfsr_state = 32'h9337_9422;

	// model state, matches the reset values
	spin_angle_t  m_ang1 = '0;
	spin_angle_t  m_ang2 = '0;
	wacko_pos_t   m_wx = '0;
	wacko_pos_t   m_wy = '0;
	kroozr_pos_t  m_kx = '0;
	kroozr_pos_t  m_ky = '0;
	logic [1:0]   m_btns = '0;

	input_subsystem UUT (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (num_rows > 0 && cycle_count >= 2 * num_rows * 8) begin
			$display("timeout: the table did not finish within %0d cycles", cycle_count);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	// ========================================================================
	// random bits, taps 32 22 2 1
	// ========================================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// ========================================================================
	// reference model
	// ========================================================================
	function automatic logic is_rotated(input game_id_t g);
		return g == game_shollow || g == game_tron;
	endfunction

	function automatic logic is_alternating(input game_id_t g);
		return !(g == game_tron || g == game_twotiger);
	endfunction

	// up to right, down to left, left to up, right to down
	function automatic joy_word_t turn_stick(input joy_word_t w);
		return {w[7:4], w[1], w[0], w[2], w[3]};
	endfunction

	function automatic spin_angle_t step_angle(input spin_angle_t a, input joy_word_t p);
		logic ccw;
		logic cw;
		ccw = p[joy_left] | p[joy_up];
		cw  = p[joy_right] | p[joy_down];
		if (ccw && !cw)
			return spin_angle_t'(a - 7'd1);
		if (cw && !ccw)
			return spin_angle_t'(a + 7'd1);
		return a;
	endfunction

	function automatic kroozr_pos_t clamp_pos(input int v);
		if (v > 511)
			return kroozr_pos_t'(511);
		if (v < -512)
			return kroozr_pos_t'(-512);
		return kroozr_pos_t'(v);
	endfunction

	task model_row(inout step_t s);
		joy_word_t  a;
		joy_word_t  b;
		joy_word_t  p1;
		joy_word_t  p2;
		int         mx;
		int         my;
		logic [7:0] act;
		a = s.joyswap ? s.joy1 : s.joy0;
		b = s.joyswap ? s.joy0 : s.joy1;
		if (s.rotate && is_rotated(s.game)) begin
			a = turn_stick(a);
			b = turn_stick(b);
		end
		p1 = a;
		p2 = is_alternating(s.game) ? a : b;
		if (s.vs_pulse) begin
			m_ang1 = step_angle(m_ang1, p1);
			m_ang2 = step_angle(m_ang2, p2);
		end
		if (s.strobe) begin
			mx     = s.rotate ? -int'($signed(s.dy)) : int'($signed(s.dx));
			my     = s.rotate ? int'($signed(s.dx)) : int'($signed(s.dy));
			m_wx   = wacko_pos_t'(int'(m_wx) + mx);
			m_wy   = wacko_pos_t'(int'(m_wy) + my);
			m_kx   = clamp_pos(int'(m_kx) - mx);
			m_ky   = clamp_pos(int'(m_ky) + my);
			m_btns = s.flags[1:0];
		end
		// port 0, active high first
		act    = '0;
		act[7] = s.service;
		act[3] = p2[joy_start];
		act[2] = p1[joy_start];
		act[1] = p2[joy_coin];
		act[0] = p1[joy_coin];
		if (s.game == game_tron || s.game == game_domino)
			act[4] = p1[joy_fire_a];
		if (s.game == game_kroozr)
			act[4] = p1[joy_fire_a] | m_btns[0];
		s.exp_in0 = ~act;
		s.exp_in1 = 8'hff;
		s.exp_in2 = 8'hff;
		s.exp_in3 = 8'hff;
		s.exp_in4 = 8'hff;
		if (s.game == game_shollow) begin
			s.exp_in1 = ~{p2[joy_fire_a], p2[joy_fire_b], p2[joy_right], p2[joy_left],
				p1[joy_fire_a], p1[joy_fire_b], p1[joy_right], p1[joy_left]};
			s.exp_in3 = ~dip_rotated;
		end else if (s.game == game_tron) begin
			s.exp_in2 = ~{p2[3:0], p1[3:0]};
			s.exp_in3 = ~{p2[joy_fire_a], dip_rotated[6:0]};
		end else if (s.game == game_wacko) begin
			s.exp_in1 = m_wx[10:3];
			s.exp_in2 = m_wy[10:3];
			s.exp_in4 = ~{p2[3:0], p1[3:0]};
		end
		// upright cabinets share one switch setting
		if (s.game == game_wacko || s.game == game_kroozr || s.game == game_domino)
			s.exp_in3 = ~dip_upright;
		s.exp_ang1 = m_ang1;
		s.exp_ang2 = m_ang2;
		s.exp_kx   = m_kx;
		s.exp_ky   = m_ky;
	endtask

	task add_row(input game_id_t game, input joy_word_t j0, input joy_word_t j1,
		input logic rot, input logic swap, input logic svc, input logic vsp,
		input logic stb, input mouse_delta_t dx, input mouse_delta_t dy,
		input logic [7:0] flags);
		step_t s;
		s          = '0;
		s.game     = game;
		s.joy0     = j0;
		s.joy1     = j1;
		s.rotate   = rot;
		s.joyswap  = swap;
		s.service  = svc;
		s.vs_pulse = vsp;
		s.strobe   = stb;
		s.dx       = dx;
		s.dy       = dy;
		s.flags    = flags;
		model_row(s);
		steps.push_back(s);
	endtask

	// ========================================================================
	// stimulus table
	// ========================================================================
	task build_table;
		logic [31:0] j0;
		logic [31:0] j1;
		logic [31:0] dx;
		logic [31:0] dy;
		logic [31:0] bit1;
		add_row(game_shollow, 8'h00, 8'h00, 0, 0, 0, 0, 0, 9'sd0, 9'sd0, 8'h00);
		for (int b = 0; b < 8; b++)
			add_row(game_shollow, 8'h01 << b, 8'h00, 0, 0, 0, 0, 0, 9'sd0, 9'sd0, 8'h00);
		add_row(game_shollow, 8'h00, 8'h00, 0, 0, 1, 0, 0, 9'sd0, 9'sd0, 8'h00);
		// rotation, swap and one-player copy
		add_row(game_shollow, 8'h08, 8'h00, 1, 0, 0, 0, 0, 9'sd0, 9'sd0, 8'h00);
		add_row(game_shollow, 8'h00, 8'h11, 1, 1, 0, 0, 0, 9'sd0, 9'sd0, 8'h00);
		add_row(game_tron, 8'h01, 8'h24, 1, 1, 0, 0, 0, 9'sd0, 9'sd0, 8'h00);
		add_row(game_domino, 8'h40, 8'h80, 1, 0, 0, 0, 0, 9'sd0, 9'sd0, 8'h00);
		// spinners, player 2 wraps below zero
		for (int i = 0; i < 4; i++)
			add_row(game_tron, 8'h01, 8'h02, 0, 0, 0, 1, 0, 9'sd0, 9'sd0, 8'h00);
		for (int i = 0; i < 2; i++)
			add_row(game_tron, 8'h03, 8'h0c, 0, 0, 0, 1, 0, 9'sd0, 9'sd0, 8'h00);
		add_row(game_tron, 8'h04, 8'h08, 0, 0, 0, 0, 0, 9'sd0, 9'sd0, 8'h00);
		for (int i = 0; i < 6; i++) begin
			draw_bits(8, j0);
			draw_bits(8, j1);
			draw_bits(1, bit1);
			add_row(i < 2 ? game_twotiger : game_tron, j0[7:0], j1[7:0], 0, 0, 0,
				bit1[0], 0, 9'sd0, 9'sd0, 8'h00);
		end
		// wacko mouse, random moves
		for (int i = 0; i < 8; i++) begin
			draw_bits(9, dx);
			draw_bits(9, dy);
			draw_bits(1, bit1);
			draw_bits(8, j0);
			add_row(game_wacko, j0[7:0], 8'h00, bit1[0], 0, 0, 0, 1,
				mouse_delta_t'(dx[8:0]), mouse_delta_t'(dy[8:0]), 8'h00);
		end
		// krooz'r drives both axes into the clamps
		for (int i = 0; i < 4; i++)
			add_row(game_kroozr, 8'h00, 8'h00, 0, 0, 0, 0, 1, -9'sd255, 9'sd255, 8'h01);
		for (int i = 0; i < 5; i++)
			add_row(game_kroozr, 8'h00, 8'h00, 0, 0, 0, 0, 1, 9'sd255, -9'sd256, 8'h02);
		for (int i = 0; i < 2; i++) begin
			draw_bits(9, dx);
			draw_bits(9, dy);
			add_row(game_kroozr, 8'h10, 8'h00, 0, 0, 0, 0, 1,
				mouse_delta_t'(dx[8:0]), mouse_delta_t'(dy[8:0]), 8'h00);
		end
	endtask

	// ========================================================================
	// compare tasks
	// ========================================================================
	task check_port(input string what, input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s expected %02h got %02h", $time, what, exp, got);
			$display("Simulation failed");
			$fatal(1, "port value mismatch");
		end
	endtask

	task check_angle(input string what, input spin_angle_t exp, input spin_angle_t got);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s expected %0d got %0d", $time, what, exp, got);
			$display("Simulation failed");
			$fatal(1, "spinner angle mismatch");
		end
	endtask

	// only the sign and bits 7..2 reach the port
	task check_pos(input string what, input kroozr_pos_t exp, input logic [7:0] port_byte);
		kroozr_pos_t got;
		kroozr_pos_t want;
		got  = {port_byte[7], port_byte[6], port_byte[5:0], 2'b00};
		want = {exp[9], exp[9], exp[7:2], 2'b00};
		if (got !== want) begin
			$display("[FAIL] %0t: %s expected %0d read back %0d", $time, what, want, got);
			$display("Simulation failed");
			$fatal(1, "mouse position mismatch");
		end
	endtask

	task apply_row(input step_t s);
		@(posedge clk_sys);
		game_sel     <= s.game;
		joystick_0   <= s.joy0;
		joystick_1   <= s.joy1;
		rotate       <= s.rotate;
		joyswap      <= s.joyswap;
		service      <= s.service;
		mouse_x      <= s.dx;
		mouse_y      <= s.dy;
		mouse_flags  <= s.flags;
		mouse_strobe <= s.strobe;
		vs           <= s.vs_pulse;
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
		vs           <= 1'b0;
		// angle lands one clock after the edge detect
		if (s.vs_pulse)
			@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task check_row(input step_t s, input int idx);
		check_port($sformatf("row %0d port 0", idx), s.exp_in0, input_0);
		check_port($sformatf("row %0d port 3", idx), s.exp_in3, input_3);
		case (s.game)
			game_shollow, game_wacko: begin
				check_port($sformatf("row %0d port 1", idx), s.exp_in1, input_1);
				check_port($sformatf("row %0d port 2", idx), s.exp_in2, input_2);
				check_port($sformatf("row %0d port 4", idx), s.exp_in4, input_4);
			end
			game_tron, game_twotiger: begin
				check_angle($sformatf("row %0d spinner 1", idx), s.exp_ang1,
					spin_angle_t'(~input_1[6:0]));
				check_angle($sformatf("row %0d spinner 2", idx), s.exp_ang2,
					spin_angle_t'(~input_4[6:0]));
				if (s.game == game_tron)
					check_port($sformatf("row %0d port 2", idx), s.exp_in2, input_2);
			end
			game_kroozr: begin
				check_pos($sformatf("row %0d kroozr x", idx), s.exp_kx, input_2);
				check_pos($sformatf("row %0d kroozr y", idx), s.exp_ky, input_4);
			end
			default: begin
				check_port($sformatf("row %0d port 4", idx), s.exp_in4, input_4);
			end
		endcase
	endtask

	initial begin
		rst_n        = 1'b0;
		game_sel     = game_shollow;
		joystick_0   = '0;
		joystick_1   = '0;
		rotate       = 1'b0;
		joyswap      = 1'b0;
		service      = 1'b0;
		vs           = 1'b0;
		mouse_x      = '0;
		mouse_y      = '0;
		mouse_strobe = 1'b0;
		mouse_flags  = '0;
		build_table();
		num_rows = steps.size();
		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;
		foreach (steps[i]) begin
			apply_row(steps[i]);
			check_row(steps[i], i);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: hdl/input_subsystem.sv
/* player-control front end, merge, two spinners, mouse tracker and port mux */

`timescale 1ns/1ps

module input_subsystem (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  game_cfg_pkg::game_id_t game_sel,
	input  ctrl_pkg::joy_word_t    joystick_0,
	input  ctrl_pkg::joy_word_t    joystick_1,
	input  logic                   rotate,
	input  logic                   joyswap,
	input  logic                   service,
	input  logic                   vs,
	input  ctrl_pkg::mouse_delta_t mouse_x,
	input  ctrl_pkg::mouse_delta_t mouse_y,
	input  logic                   mouse_strobe,
	input  logic [7:0]             mouse_flags,
	output logic [7:0]             input_0,
	output logic [7:0]             input_1,
	output logic [7:0]             input_2,
	output logic [7:0]             input_3,
	output logic [7:0]             input_4
);
	import ctrl_pkg::*;

	joy_word_t    player1;
	joy_word_t    player2;
	spin_angle_t  spin_angle1;
	spin_angle_t  spin_angle2;
	wacko_pos_t   wacko_x;
	wacko_pos_t   wacko_y;
	kroozr_pos_t  kroozr_x;
	kroozr_pos_t  kroozr_y;
	logic [1:0]   mouse_btns;

	control_merge merge (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.game_sel   (game_sel),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.joyswap    (joyswap),
		.player1    (player1),
		.player2    (player2)
	);

	// left or up turns down, right or down turns up
	frame_spinner spinner1 (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.vs         (vs),
		.turn_left  (player1[joy_left] | player1[joy_up]),
		.turn_right (player1[joy_right] | player1[joy_down]),
		.spin_angle (spin_angle1)
	);

	frame_spinner spinner2 (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.vs         (vs),
		.turn_left  (player2[joy_left] | player2[joy_up]),
		.turn_right (player2[joy_right] | player2[joy_down]),
		.spin_angle (spin_angle2)
	);

	mouse_tracker mouse (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.rotate       (rotate),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_strobe (mouse_strobe),
		.mouse_flags  (mouse_flags),
		.wacko_x      (wacko_x),
		.wacko_y      (wacko_y),
		.kroozr_x     (kroozr_x),
		.kroozr_y     (kroozr_y),
		.mouse_btns   (mouse_btns)
	);

	input_port_mux port_mux (
		.game_sel    (game_sel),
		.service     (service),
		.player1     (player1),
		.player2     (player2),
		.spin_angle1 (spin_angle1),
		.spin_angle2 (spin_angle2),
		.wacko_x     (wacko_x),
		.wacko_y     (wacko_y),
		.kroozr_x    (kroozr_x),
		.kroozr_y    (kroozr_y),
		.mouse_btns  (mouse_btns),
		.input_0     (input_0),
		.input_1     (input_1),
		.input_2     (input_2),
		.input_3     (input_3),
		.input_4     (input_4)
	);

endmodule

// File: hdl/input_port_mux.sv
/* per-game layout of the five active-low input ports */

`timescale 1ns/1ps

module input_port_mux (
	input  game_cfg_pkg::game_id_t game_sel,
	input  logic                   service,
	input  ctrl_pkg::joy_word_t    player1,
	input  ctrl_pkg::joy_word_t    player2,
	input  ctrl_pkg::spin_angle_t  spin_angle1,
	input  ctrl_pkg::spin_angle_t  spin_angle2,
	input  ctrl_pkg::wacko_pos_t   wacko_x,
	input  ctrl_pkg::wacko_pos_t   wacko_y,
	input  ctrl_pkg::kroozr_pos_t  kroozr_x,
	input  ctrl_pkg::kroozr_pos_t  kroozr_y,
	input  logic [1:0]             mouse_btns,
	output logic [7:0]             input_0,
	output logic [7:0]             input_1,
	output logic [7:0]             input_2,
	output logic [7:0]             input_3,
	output logic [7:0]             input_4
);
	import game_cfg_pkg::*;
	import ctrl_pkg::*;

	logic game_btn;

	// ========================================================================
	// port 0 bit 4 differs per game
	// ========================================================================
	always_comb begin
		case (game_sel)
			game_tron, game_domino: game_btn = player1[joy_fire_a];
			game_kroozr:            game_btn = player1[joy_fire_a] | mouse_btns[0];
			default:                game_btn = 1'b0;
		endcase
	end

	// service, tilt, game button, starts, coins
	assign input_0 = ~{service, 1'b0, 1'b0, game_btn, player2[joy_start],
		player1[joy_start], player2[joy_coin], player1[joy_coin]};

	// ========================================================================
	// ports 1 to 4
	// ========================================================================
	always_comb begin
		input_1 = port_idle;
		input_2 = port_idle;
		input_3 = port_idle;
		input_4 = port_idle;
		case (game_sel)
			game_shollow: begin
				input_1 = ~{player2[joy_fire_a], player2[joy_fire_b],
					player2[joy_right], player2[joy_left],
					player1[joy_fire_a], player1[joy_fire_b],
					player1[joy_right], player1[joy_left]};
				input_3 = ~dip_rotated;
			end
			game_tron: begin
				input_1 = ~{1'b0, spin_angle1};
				input_2 = ~{player2[3:0], player1[3:0]};
				input_3 = ~{player2[joy_fire_a], dip_rotated[6:0]};
				input_4 = ~{1'b0, spin_angle2};
			end
			game_twotiger: begin
				input_1 = ~{1'b0, spin_angle1};
				input_2 = ~{4'b0000, player2[joy_fire_b], player2[joy_fire_a],
					player1[joy_fire_b], player1[joy_fire_a]};
				input_4 = ~{1'b0, spin_angle2};
			end
			game_wacko: begin
				// position bytes go out as they are
				input_1 = wacko_x[10:3];
				input_2 = wacko_y[10:3];
				input_3 = ~dip_upright;
				input_4 = ~{player2[joy_up], player2[joy_down],
					player2[joy_left], player2[joy_right],
					player1[joy_up], player1[joy_down],
					player1[joy_left], player1[joy_right]};
			end
			game_kroozr: begin
				input_1 = ~{player1[joy_fire_b] | mouse_btns[1], spin_angle1[6],
					3'b000, spin_angle1[5:3]};
				// sign stands in for bit 8
				input_2 = {kroozr_x[9], kroozr_x[9], kroozr_x[7:2]};
				input_3 = ~dip_upright;
				input_4 = {kroozr_y[9], kroozr_y[9], kroozr_y[7:2]};
			end
			game_domino: begin
				input_1 = ~{4'b0000, player1[3:0]};
				input_2 = ~{3'b000, player2[joy_fire_a], player2[3:0]};
				input_3 = ~dip_upright;
			end
			default: begin
				input_1 = port_idle;
			end
		endcase
	end

endmodule

// File: hdl/mouse_tracker.sv
/* wacko wrapping position, krooz'r saturating position and latched mouse buttons */

`timescale 1ns/1ps

module mouse_tracker (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   rotate,
	input  ctrl_pkg::mouse_delta_t mouse_x,
	input  ctrl_pkg::mouse_delta_t mouse_y,
	input  logic                   mouse_strobe,
	input  logic [7:0]             mouse_flags,
	output ctrl_pkg::wacko_pos_t   wacko_x,
	output ctrl_pkg::wacko_pos_t   wacko_y,
	output ctrl_pkg::kroozr_pos_t  kroozr_x,
	output ctrl_pkg::kroozr_pos_t  kroozr_y,
	output logic [1:0]             mouse_btns
);
	import ctrl_pkg::*;

	// 11 bits so that negating -256 stays exact
	logic signed [10:0] ext_x;
	logic signed [10:0] ext_y;
	logic signed [10:0] move_x;
	logic signed [10:0] move_y;
	logic signed [10:0] kx_sum;
	logic signed [10:0] ky_sum;

	function automatic kroozr_pos_t clamp_kroozr(input logic signed [10:0] v);
		if (v > kroozr_max) begin
			return kroozr_pos_t'(kroozr_max);
		end else if (v < -kroozr_max - 1) begin
			return kroozr_pos_t'(-kroozr_max - 1);
		end else begin
			return v[9:0];
		end
	endfunction

	assign ext_x = mouse_x;
	assign ext_y = mouse_y;

	// rotated cabinet turns the mouse a quarter
	assign move_x = rotate ? -ext_y : ext_x;
	assign move_y = rotate ? ext_x : ext_y;

	// krooz'r x axis runs opposite
	assign kx_sum = kroozr_x - move_x;
	assign ky_sum = kroozr_y + move_y;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wacko_x    <= '0;
			wacko_y    <= '0;
			kroozr_x   <= '0;
			kroozr_y   <= '0;
			mouse_btns <= '0;
		end else if (mouse_strobe) begin
			wacko_x    <= wacko_x + move_x;
			wacko_y    <= wacko_y + move_y;
			kroozr_x   <= clamp_kroozr(kx_sum);
			kroozr_y   <= clamp_kroozr(ky_sum);
			mouse_btns <= mouse_flags[1:0];
		end
	end

endmodule

// File: hdl/frame_spinner.sv
/* spinner angle, one step per rising edge of vertical sync */

`timescale 1ns/1ps

module frame_spinner (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  vs,
	input  logic                  turn_left,
	input  logic                  turn_right,
	output ctrl_pkg::spin_angle_t spin_angle
);
	import ctrl_pkg::*;

	logic vs_sync;
	logic vs_last;
	logic vs_rise;

	// vs history for edge detection
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vs_sync <= 1'b0;
			vs_last <= 1'b0;
		end else begin
			vs_sync <= vs;
			vs_last <= vs_sync;
		end
	end

	assign vs_rise = vs_sync & ~vs_last;

	// ========================================================================
	// angle counter, wraps modulo 128
	// ========================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			spin_angle <= '0;
		end else if (vs_rise) begin
			if (turn_left && !turn_right) begin
				spin_angle <= spin_angle - spin_angle_t'(1);
			end else if (turn_right && !turn_left) begin
				spin_angle <= spin_angle + spin_angle_t'(1);
			end
			// both or neither held, angle stays put
		end
	end

endmodule

// File: hdl/control_merge.sv
/* joystick swap, rotation remap and one-player copy into registered player words */

`timescale 1ns/1ps

module control_merge (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  game_cfg_pkg::game_id_t game_sel,
	input  ctrl_pkg::joy_word_t    joystick_0,
	input  ctrl_pkg::joy_word_t    joystick_1,
	input  logic                   rotate,
	input  logic                   joyswap,
	output ctrl_pkg::joy_word_t    player1,
	output ctrl_pkg::joy_word_t    player2
);
	import game_cfg_pkg::*;
	import ctrl_pkg::*;

	joy_word_t swap_p1;
	joy_word_t swap_p2;
	joy_word_t rot_p1;
	joy_word_t rot_p2;
	logic      do_rotate;

	// quarter turn of the stick for side-mounted monitors
	function automatic joy_word_t rotate_dirs(input joy_word_t w);
		joy_word_t r;
		r            = w;
		r[joy_right] = w[joy_up];
		r[joy_left]  = w[joy_down];
		r[joy_up]    = w[joy_left];
		r[joy_down]  = w[joy_right];
		return r;
	endfunction

	assign swap_p1 = joyswap ? joystick_1 : joystick_0;
	assign swap_p2 = joyswap ? joystick_0 : joystick_1;

	// only remap when the game really is rotated
	assign do_rotate = rotate & game_rotated[game_sel];

	assign rot_p1 = do_rotate ? rotate_dirs(swap_p1) : swap_p1;
	assign rot_p2 = do_rotate ? rotate_dirs(swap_p2) : swap_p2;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			player1 <= '0;
			player2 <= '0;
		end else begin
			player1 <= rot_p1;
			// alternating play shares one stick
			if (game_is_oneplayer[game_sel]) begin
				player2 <= rot_p1;
			end else begin
				player2 <= rot_p2;
			end
		end
	end

endmodule

// File: hdl/ctrl_pkg.sv
/* joystick word layout, control bit positions,
   spinner angle and mouse position widths */

package ctrl_pkg;

	// ========================================================================
	// joystick and player words
	// ========================================================================
	typedef logic [7:0] joy_word_t;

	localparam int joy_right  = 0;
	localparam int joy_left   = 1;
	localparam int joy_down   = 2;
	localparam int joy_up     = 3;
	localparam int joy_fire_a = 4;
	localparam int joy_fire_b = 5;
	localparam int joy_start  = 6;
	localparam int joy_coin   = 7;

	// ========================================================================
	// spinner and mouse
	// ========================================================================
	typedef logic [6:0] spin_angle_t;

	// one relative move from the mouse
	typedef logic signed [8:0] mouse_delta_t;

	// wraps freely
	typedef logic signed [10:0] wacko_pos_t;

	// saturates, range -512 .. +511
	typedef logic signed [9:0] kroozr_pos_t;

	localparam int kroozr_max = 511;

endpackage

// File: hdl/game_cfg_pkg.sv
/* game identifiers, per-game orientation and player-mode tables,
   idle port value and dipswitch patterns */

package game_cfg_pkg;

	// ========================================================================
	// game select encoding
	// ========================================================================
	typedef enum logic [2:0] {
		game_shollow  = 3'd0,
		game_tron     = 3'd1,
		game_twotiger = 3'd2,
		game_wacko    = 3'd3,
		game_kroozr   = 3'd4,
		game_domino   = 3'd5
	} game_id_t;

	// one bit per encoding, unused codes 6 and 7 stay clear
	// alternating play, player 2 follows player 1
	localparam logic [7:0] game_is_oneplayer = 8'b0011_1001;

	// cabinet mounted on its side
	localparam logic [7:0] game_rotated = 8'b0000_0011;

	// ========================================================================
	// port constants
	// ========================================================================
	// unused active-low port
	localparam logic [7:0] port_idle = 8'hff;

	// dipswitch settings, active high before inversion onto port 3
	localparam logic [7:0] dip_rotated = 8'h02;
	localparam logic [7:0] dip_upright = 8'h40;

endpackage
